// ==== source/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN        = 32;
    localparam int NB_REG_ADDR = 5;

    typedef logic [NB_REG_ADDR-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]        word_t;

    // ------------------------------
    // Instruction fields
    // ------------------------------
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        BEQ    = 6'h04,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Operand source for the ALU inputs
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // ------------------------------
    // Pipeline registers
    // ------------------------------
    // All-zero control is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc_plus4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc_plus4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     br_target;
        word_t     alu_result;
        logic      alu_zero;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     wdata;
    } mem_wb_t;

endpackage

// ==== source/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  mips_pkg::word_t               i_imem_data,
    input  logic                          i_stall,
    input  logic                          i_branch_taken,
    input  mips_pkg::word_t               i_branch_target,
    output mips_pkg::if_id_t              o_if_id
);
    import mips_pkg::*;

    localparam int NB_IADDR = $clog2(IMEM_DEPTH);

    word_t pc;
    word_t pc_plus4;
    word_t instr;
    word_t imem [IMEM_DEPTH];

    assign pc_plus4 = pc + 32'd4;

    // Word addressed, asynchronous read
    assign instr = imem[pc[NB_IADDR+1:2]];

    always_ff @(posedge i_clk) begin
        if (i_imem_we && !i_rst) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Branch from the memory stage wins over a load-use stall
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc      <= '0;
            o_if_id <= '0;
        end else if (i_branch_taken) begin
            pc      <= i_branch_target;
            o_if_id <= '0;
        end else if (!i_stall) begin
            pc               <= pc_plus4;
            o_if_id.pc_plus4 <= pc_plus4;
            o_if_id.instr    <= instr;
        end
    end

    // Program is only loaded while the core sits in reset
    a_load_in_reset: assert property (@(posedge i_clk) i_imem_we |-> !i_rst);

endmodule

// ==== source/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mips_pkg::if_id_t  i_if_id,
    input  mips_pkg::id_ex_t  i_id_ex_prev,
    input  mips_pkg::mem_wb_t i_mem_wb,
    input  logic              i_branch_taken,
    output mips_pkg::id_ex_t  o_id_ex,
    output logic              o_stall
);
    import mips_pkg::*;

    localparam int NUM_REGS = 2 ** NB_REG_ADDR;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t dest;
    word_t     imm;
    word_t     rs_data;
    word_t     rt_data;
    ctrl_t     ctrl;
    word_t     regs [NUM_REGS];

    assign opcode = opcode_e'(i_if_id.instr[31:26]);
    assign funct  = funct_e'(i_if_id.instr[5:0]);
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign imm    = {{(XLEN-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};
    assign dest   = (opcode == R_TYPE) ? rd : rt;

    // ------------------------------
    // Control decoder
    // ------------------------------
    always_comb begin
        ctrl = '0;
        case (opcode)
            R_TYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    ADD:     ctrl.alu_op = ALU_ADD;
                    SUB:     ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    OR:      ctrl.alu_op = ALU_OR;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    // Unknown funct, including the all-zero word
                    default: ctrl = '0;
                endcase
            end
            ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            default: ctrl = '0;
        endcase
    end

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_mem_wb.reg_write && (i_mem_wb.dest != '0)) begin
            regs[i_mem_wb.dest] <= i_mem_wb.wdata;
        end
    end

    // Write-back value passes straight through to a read of the same register
    function automatic word_t read_reg(input reg_addr_t addr);
        word_t value;
        value = regs[addr];
        if (i_mem_wb.reg_write && (i_mem_wb.dest == addr) && (addr != '0)) begin
            value = i_mem_wb.wdata;
        end
        return value;
    endfunction

    always_comb begin
        rs_data = read_reg(rs);
        rt_data = read_reg(rt);
    end

    // Load in EX feeding this instruction
    assign o_stall = i_id_ex_prev.ctrl.mem_read && (i_id_ex_prev.dest != '0) &&
                     ((i_id_ex_prev.dest == rs) || (i_id_ex_prev.dest == rt));

    always_ff @(posedge i_clk) begin
        if (!i_rst || i_branch_taken || o_stall) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.ctrl     <= ctrl;
            o_id_ex.pc_plus4 <= i_if_id.pc_plus4;
            o_id_ex.rs_data  <= rs_data;
            o_id_ex.rt_data  <= rt_data;
            o_id_ex.imm      <= imm;
            o_id_ex.rs       <= rs;
            o_id_ex.rt       <= rt;
            o_id_ex.dest     <= dest;
        end
    end

    // Load-use stall lasts a single cycle
    a_stall_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_stall |=> !o_stall);

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic               i_clk,
    input  logic               i_rst,
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::mem_wb_t  i_mem_wb,
    input  mips_pkg::fwd_sel_e i_fwd_a,
    input  mips_pkg::fwd_sel_e i_fwd_b,
    input  logic               i_branch_taken,
    output mips_pkg::ex_mem_t  o_ex_mem
);
    import mips_pkg::*;

    word_t op_a;
    word_t rt_value;
    word_t op_b;
    word_t alu_result;
    word_t br_target;

    // Newer result from EX/MEM, older one from MEM/WB
    function automatic word_t forward(input fwd_sel_e sel, input word_t reg_value);
        case (sel)
            FWD_MEM: return o_ex_mem.alu_result;
            FWD_WB:  return i_mem_wb.wdata;
            default: return reg_value;
        endcase
    endfunction

    always_comb begin
        op_a     = forward(i_fwd_a, i_id_ex.rs_data);
        rt_value = forward(i_fwd_b, i_id_ex.rt_data);
    end

    assign op_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rt_value;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_result = '0;
        endcase
    end

    assign br_target = i_id_ex.pc_plus4 + {i_id_ex.imm[XLEN-3:0], 2'b00};

    always_ff @(posedge i_clk) begin
        if (!i_rst || i_branch_taken) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
            o_ex_mem.br_target  <= br_target;
            o_ex_mem.alu_result <= alu_result;
            o_ex_mem.alu_zero   <= (alu_result == '0);
            // Store data sees the same forwarding as operand B
            o_ex_mem.store_data <= rt_value;
            o_ex_mem.dest       <= i_id_ex.dest;
        end
    end

endmodule

// ==== source/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit (
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::ex_mem_t  i_ex_mem,
    input  mips_pkg::mem_wb_t  i_mem_wb,
    output mips_pkg::fwd_sel_e o_fwd_a,
    output mips_pkg::fwd_sel_e o_fwd_b
);
    import mips_pkg::*;

    // MEM/WB never carries a write to register 0
    function automatic fwd_sel_e pick_source(input reg_addr_t src);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (i_mem_wb.reg_write && (i_mem_wb.dest == src)) begin
            sel = FWD_WB;
        end
        // The younger producer takes priority
        if (i_ex_mem.ctrl.reg_write && (i_ex_mem.dest != '0) && (i_ex_mem.dest == src)) begin
            sel = FWD_MEM;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_a = pick_source(i_id_ex.rs);
        o_fwd_b = pick_source(i_id_ex.rt);
    end

    // Register 0 always reads as zero, so it is never forwarded
    always_comb begin
        a_no_fwd_reg0: assert final (((o_fwd_a == FWD_NONE) || (i_id_ex.rs != '0)) &&
                                     ((o_fwd_b == FWD_NONE) || (i_id_ex.rt != '0)));
    end

endmodule

// ==== source/memory_access.sv ====
`timescale 1ns/1ps

module memory_access #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::mem_wb_t o_mem_wb,
    output logic              o_branch_taken,
    output mips_pkg::word_t   o_branch_target
);
    import mips_pkg::*;

    localparam int NB_DADDR = $clog2(DMEM_DEPTH);

    logic [NB_DADDR-1:0] addr;
    word_t               read_data;
    word_t               dmem [DMEM_DEPTH];

    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = '0;
        end
    end

    assign addr      = i_ex_mem.alu_result[NB_DADDR+1:2];
    assign read_data = dmem[addr];

    always @(posedge i_clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    // BEQ resolves here and flushes the three younger stages
    assign o_branch_taken  = i_ex_mem.ctrl.branch && i_ex_mem.alu_zero;
    assign o_branch_target = i_ex_mem.br_target;

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.reg_write <= i_ex_mem.ctrl.reg_write && (i_ex_mem.dest != '0);
            o_mem_wb.dest      <= i_ex_mem.dest;
            o_mem_wb.wdata     <= i_ex_mem.ctrl.mem_to_reg ? read_data : i_ex_mem.alu_result;
        end
    end

    // Decoder never marks an instruction as both load and store
    a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rst)
        !(i_ex_mem.ctrl.mem_read && i_ex_mem.ctrl.mem_write));

endmodule

// ==== source/mips_top.sv ====
`timescale 1ns/1ps

module mips_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    // Program load port, used while reset is held
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  mips_pkg::word_t               i_imem_data,
    // Retired register writes
    output logic                          o_wb_valid,
    output mips_pkg::reg_addr_t           o_wb_reg,
    output mips_pkg::word_t               o_wb_data,
    // Data memory stores
    output logic                          o_st_valid,
    output mips_pkg::word_t               o_st_addr,
    output mips_pkg::word_t               o_st_data
);
    import mips_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     stall;
    logic     branch_taken;
    word_t    branch_target;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    // ------------------------------
    // Pipeline stages
    // ------------------------------
    instruction_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_instruction_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_if_id         (if_id)
    );

    instruction_decode u_instruction_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_if_id        (if_id),
        .i_id_ex_prev   (id_ex),
        .i_mem_wb       (mem_wb),
        .i_branch_taken (branch_taken),
        .o_id_ex        (id_ex),
        .o_stall        (stall)
    );

    execute u_execute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_id_ex        (id_ex),
        .i_mem_wb       (mem_wb),
        .i_fwd_a        (fwd_a),
        .i_fwd_b        (fwd_b),
        .i_branch_taken (branch_taken),
        .o_ex_mem       (ex_mem)
    );

    forwarding_unit u_forwarding_unit (
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_mem_wb (mem_wb),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b)
    );

    memory_access #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_memory_access (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_ex_mem        (ex_mem),
        .o_mem_wb        (mem_wb),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    // Observation strobes
    assign o_wb_valid = mem_wb.reg_write;
    assign o_wb_reg   = mem_wb.dest;
    assign o_wb_data  = mem_wb.wdata;
    assign o_st_valid = ex_mem.ctrl.mem_write;
    assign o_st_addr  = ex_mem.alu_result;
    assign o_st_data  = ex_mem.store_data;

endmodule

// ==== include/mips_ref_model.svh ====
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// Expected results in program order
reg_addr_t exp_wb_reg  [$];
word_t     exp_wb_data [$];
word_t     exp_st_addr [$];
word_t     exp_st_data [$];

word_t     model_regs [32];
word_t     model_mem  [DMEM_DEPTH];

function automatic word_t sign_extend(input logic [15:0] value);
    return {{16{value[15]}}, value};
endfunction

// Register 0 is hardwired to zero and never reported
function automatic void model_write(input reg_addr_t dest, input word_t value);
    if (dest != '0) begin
        model_regs[dest] = value;
        exp_wb_reg.push_back(dest);
        exp_wb_data.push_back(value);
    end
endfunction

// ------------------------------
// Instruction-level model
// ------------------------------
task automatic run_model();
    word_t      pc;
    word_t      instr;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      addr;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [5:0] op;
    logic [5:0] funct;
    foreach (model_regs[i]) model_regs[i] = '0;
    foreach (model_mem[i]) model_mem[i] = '0;
    pc = '0;
    // Branches only go forward, so the program always runs off its end
    while (pc < 4 * N_INSTR) begin
        instr = prog[pc >> 2];
        op    = instr[31:26];
        funct = instr[5:0];
        rs    = instr[25:21];
        rt    = instr[20:16];
        rd    = instr[15:11];
        a     = model_regs[rs];
        b     = model_regs[rt];
        imm   = sign_extend(instr[15:0]);
        pc    = pc + 4;
        case (op)
            R_TYPE: begin
                case (funct)
                    ADD:     model_write(rd, a + b);
                    SUB:     model_write(rd, a - b);
                    AND:     model_write(rd, a & b);
                    OR:      model_write(rd, a | b);
                    SLT:     model_write(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: ;
                endcase
            end
            ADDI: model_write(rt, a + imm);
            LW: begin
                addr = a + imm;
                model_write(rt, model_mem[(addr >> 2) % DMEM_DEPTH]);
            end
            SW: begin
                addr = a + imm;
                model_mem[(addr >> 2) % DMEM_DEPTH] = b;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
            end
            BEQ: begin
                if (a == b) begin
                    pc = pc + (imm << 2);
                end
            end
            default: ;
        endcase
    end
endtask

`endif

// ==== sim/tb_mips_top.sv ====
`timescale 1ns/1ps

module tb_mips_top;
    import mips_pkg::*;

    localparam int IMEM_DEPTH     = 256;
    localparam int DMEM_DEPTH     = 256;
    localparam int NB_IADDR       = $clog2(IMEM_DEPTH);
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int N_INSTR        = 150;
    localparam int MEM_WORDS      = 16;   // small window so loads hit earlier stores
    localparam int SEED           = 32'h1ac001aa;
    localparam int TIMEOUT_CYCLES = IMEM_DEPTH + RESET_CYCLES + 40 * N_INSTR + 200;

    logic                i_clk = 1'b0;
    logic                i_rst;
    logic                i_imem_we;
    logic [NB_IADDR-1:0] i_imem_addr;
    word_t               i_imem_data;
    logic                o_wb_valid;
    reg_addr_t           o_wb_reg;
    word_t               o_wb_data;
    logic                o_st_valid;
    word_t               o_st_addr;
    word_t               o_st_data;

    word_t prog [N_INSTR];

    `include "mips_ref_model.svh"

    mips_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data),
        .o_st_valid  (o_st_valid),
        .o_st_addr   (o_st_addr),
        .o_st_data   (o_st_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    // ------------------------------
    // Program generation
    // ------------------------------
    function automatic word_t encode_r(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input funct_e funct);
        return {R_TYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t encode_i(input opcode_e op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Operands from x0..x7 so dependencies are frequent
    task automatic gen_program();
        int          kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] offset;
        for (int i = 0; i < N_INSTR; i++) begin
            kind   = $urandom % 12;
            rs     = reg_addr_t'($urandom % 8);
            rt     = reg_addr_t'($urandom % 8);
            rd     = reg_addr_t'($urandom % 8);
            offset = 16'(4 * ($urandom % MEM_WORDS));
            case (kind)
                0:         prog[i] = encode_r(rs, rt, rd, ADD);
                1:         prog[i] = encode_r(rs, rt, rd, SUB);
                2:         prog[i] = encode_r(rs, rt, rd, AND);
                3:         prog[i] = encode_r(rs, rt, rd, OR);
                4:         prog[i] = encode_r(rs, rt, rd, SLT);
                5, 6, 7:   prog[i] = encode_i(ADDI, rs, rt, 16'($urandom));
                8:         prog[i] = encode_i(LW, 5'd0, rt, offset);
                9, 10:     prog[i] = encode_i(SW, 5'd0, rt, offset);
                default:   prog[i] = encode_i(BEQ, rs, rt, 16'(1 + $urandom % 4));
            endcase
        end
    endtask

    // Reset stays low for the whole load and RESET_CYCLES more
    task automatic load_program();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge i_clk);
            #1;
            i_imem_we   = 1'b1;
            i_imem_addr = NB_IADDR'(a);
            i_imem_data = (a < N_INSTR) ? prog[a] : '0;
        end
        @(posedge i_clk);
        #1;
        i_imem_we = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst = 1'b1;
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_wb(input reg_addr_t got_reg, input word_t got_data);
        reg_addr_t exp_reg;
        word_t     exp_data;
        if (exp_wb_reg.size() == 0) begin
            stop_with_failure($sformatf("Unexpected write to x%0d after all writes retired",
                                        got_reg));
        end else begin
            exp_reg  = exp_wb_reg.pop_front();
            exp_data = exp_wb_data.pop_front();
            if ((got_reg !== exp_reg) || (got_data !== exp_data)) begin
                stop_with_failure($sformatf(
                    "Mismatch at %0t: write expected x%0d = %h, got x%0d = %h",
                    $time, exp_reg, exp_data, got_reg, got_data));
            end
        end
    endtask

    task automatic check_store(input word_t got_addr, input word_t got_data);
        word_t exp_addr;
        word_t exp_data;
        if (exp_st_addr.size() == 0) begin
            stop_with_failure($sformatf("Unexpected store to %h after all stores retired",
                                        got_addr));
        end else begin
            exp_addr = exp_st_addr.pop_front();
            exp_data = exp_st_data.pop_front();
            if ((got_addr !== exp_addr) || (got_data !== exp_data)) begin
                stop_with_failure($sformatf(
                    "Mismatch at %0t: store expected [%h] = %h, got [%h] = %h",
                    $time, exp_addr, exp_data, got_addr, got_data));
            end
        end
    endtask

    // Strobes are registered, so the falling edge sees them settled
    always @(negedge i_clk) begin
        if (o_wb_valid) begin
            check_wb(o_wb_reg, o_wb_data);
        end
        if (o_st_valid) begin
            check_store(o_st_addr, o_st_data);
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog expired because retirement did not complete in time");
    end

    initial begin
        i_rst       = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        void'($urandom(SEED));
        gen_program();
        run_model();
        $display("Program of %0d instructions, expecting %0d writes and %0d stores",
                 N_INSTR, exp_wb_reg.size(), exp_st_addr.size());
        load_program();
        while ((exp_wb_reg.size() != 0) || (exp_st_addr.size() != 0)) begin
            @(posedge i_clk);
        end
        // Any strobe in this quiet window fails in the compare tasks
        repeat (20) @(posedge i_clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== mips_top.f ====
+incdir+include
source/mips_pkg.sv
source/instruction_fetch.sv
source/instruction_decode.sv
source/execute.sv
source/forwarding_unit.sv
source/memory_access.sv
source/mips_top.sv
sim/tb_mips_top.sv
